// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0 -Mdir obj_dir
TOP      = tb_cart
FILELIST = all.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+hdl
hdl/cart_pkg.sv
hdl/console_port.sv
hdl/mcu_port.sv
hdl/mem_arbiter.sv
hdl/byte_lane_steer.sv
hdl/cart_data_top.sv
tb/sram_model.sv
tb/tb_cart.sv

// ==== hdl/byte_lane_steer.sv ====
module byte_lane_steer
   import cart_pkg::*;
(
   input  logic  CLK,
   input  logic  reset,
   input  logic  lane_lo,
   input  logic  load_console,
   input  logic  load_mcu,
   input  byte_t wr_byte,
   input  word_t mem_rdata,
   output word_t mem_wdata_lanes,
   output byte_t console_rdata,
   output byte_t mcu_dat_r
);

   // Addressed byte of the SRAM word
   byte_t rd_byte;

   // Holding registers, one per side
   byte_t con_hold;
   byte_t mcu_hold;

   //////////////////////////////
   // Read lane select
   //////////////////////////////

   // Big-endian: odd address is the low byte
   always_comb begin
      if (lane_lo) begin
         rd_byte = mem_rdata[7:0];
      end else begin
         rd_byte = mem_rdata[15:8];
      end
   end

   //////////////////////////////
   // Holding registers
   //////////////////////////////

   // Console side keeps its byte until the next console read lands
   always_ff @(posedge CLK) begin
      if (reset) begin
         con_hold <= '0;
      end else if (load_console) begin
         con_hold <= rd_byte;
      end
   end

   // MCU side, valid in the ack cycle
   always_ff @(posedge CLK) begin
      if (reset) begin
         mcu_hold <= '0;
      end else if (load_mcu) begin
         mcu_hold <= rd_byte;
      end
   end

   assign console_rdata = con_hold;
   assign mcu_dat_r     = mcu_hold;

   //////////////////////////////
   // Write lane placement
   //////////////////////////////

   // Same byte on both lanes, the byte enables pick the one written
   assign mem_wdata_lanes = {wr_byte, wr_byte};

endmodule

// ==== hdl/cart_data_top.sv ====
module cart_data_top
   import cart_pkg::*;
(
   input  logic     CLK,
   input  logic     reset,
   // Console bus
   input  addr_t    console_addr,
   input  logic     console_rd_n,
   input  logic     console_wr_n,
   input  byte_t    console_wdata,
   output byte_t    console_rdata,
   output logic     console_oe,
   // MCU Wishbone
   input  logic     mcu_cyc,
   input  logic     mcu_stb,
   input  logic     mcu_we,
   input  addr_t    mcu_adr,
   input  byte_t    mcu_dat_w,
   output byte_t    mcu_dat_r,
   output logic     mcu_ack,
   // SRAM
   output waddr_t   mem_addr,
   output word_t    mem_wdata,
   output lane_en_t mem_be,
   output logic     mem_we,
   input  word_t    mem_rdata
);

   // Console request
   logic  con_req;
   logic  con_we;
   addr_t con_addr;
   byte_t con_wdata;
   logic  con_done;

   // MCU request
   logic  mreq;
   logic  mreq_we;
   addr_t mreq_addr;
   byte_t mreq_wdata;
   logic  mreq_done;

   // Arbiter to steering
   logic  lane_lo;
   logic  load_console;
   logic  load_mcu;
   byte_t wr_byte;

   console_port i_console_port (
      .CLK           (CLK),
      .reset         (reset),
      .console_addr  (console_addr),
      .console_rd_n  (console_rd_n),
      .console_wr_n  (console_wr_n),
      .console_wdata (console_wdata),
      .console_oe    (console_oe),
      .req           (con_req),
      .req_we        (con_we),
      .req_addr      (con_addr),
      .req_wdata     (con_wdata),
      .done          (con_done)
   );

   mcu_port i_mcu_port (
      .CLK       (CLK),
      .reset     (reset),
      .mcu_cyc   (mcu_cyc),
      .mcu_stb   (mcu_stb),
      .mcu_we    (mcu_we),
      .mcu_adr   (mcu_adr),
      .mcu_dat_w (mcu_dat_w),
      .mcu_ack   (mcu_ack),
      .req       (mreq),
      .req_we    (mreq_we),
      .req_addr  (mreq_addr),
      .req_wdata (mreq_wdata),
      .done      (mreq_done)
   );

   // Write word on the pins comes from the lane steering block
   mem_arbiter i_mem_arbiter (
      .CLK          (CLK),
      .reset        (reset),
      .con_req      (con_req),
      .con_we       (con_we),
      .con_addr     (con_addr),
      .con_wdata    (con_wdata),
      .con_done     (con_done),
      .mcu_req      (mreq),
      .mcu_we       (mreq_we),
      .mcu_addr     (mreq_addr),
      .mcu_wdata    (mreq_wdata),
      .mcu_done     (mreq_done),
      .mem_addr     (mem_addr),
      .mem_wdata    (),
      .mem_be       (mem_be),
      .mem_we       (mem_we),
      .lane_lo      (lane_lo),
      .load_console (load_console),
      .load_mcu     (load_mcu),
      .wr_byte      (wr_byte)
   );

   byte_lane_steer i_byte_lane_steer (
      .CLK             (CLK),
      .reset           (reset),
      .lane_lo         (lane_lo),
      .load_console    (load_console),
      .load_mcu        (load_mcu),
      .wr_byte         (wr_byte),
      .mem_rdata       (mem_rdata),
      .mem_wdata_lanes (mem_wdata),
      .console_rdata   (console_rdata),
      .mcu_dat_r       (mcu_dat_r)
   );

endmodule

// ==== hdl/cart_pkg.sv ====
`include "cart_settings.svh"

package cart_pkg;

   //////////////////////////////
   // Data widths
   //////////////////////////////

   // One data byte on either bus
   typedef logic [7:0] byte_t;

   // One SRAM word, high byte at even address
   typedef logic [15:0] word_t;

   //////////////////////////////
   // Addresses
   //////////////////////////////

   // Byte address from the console or MCU
   typedef logic [`CART_ADDR_W-1:0] addr_t;

   // SRAM word address, bit 0 of the byte address dropped
   typedef logic [`CART_ADDR_W-2:0] waddr_t;

   // Byte enables, bit 1 is the high byte
   typedef logic [1:0] lane_en_t;

   //////////////////////////////
   // Arbiter FSM
   //////////////////////////////

   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_ACCESS,
      ARB_DONE
   } arb_state_t;

endpackage

// ==== hdl/cart_settings.svh ====
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

//////////////////////////////
// Address width
//////////////////////////////

// Byte address seen by the console and the MCU
`define CART_ADDR_W 24

//////////////////////////////
// SRAM timing
//////////////////////////////

// Clocks one SRAM access holds the bus, 1 to 8
`define MEM_CYCLES 2

`endif

// ==== hdl/console_port.sv ====
module console_port
   import cart_pkg::*;
(
   input  logic  CLK,
   input  logic  reset,
   input  addr_t console_addr,
   input  logic  console_rd_n,
   input  logic  console_wr_n,
   input  byte_t console_wdata,
   output logic  console_oe,
   output logic  req,
   output logic  req_we,
   output addr_t req_addr,
   output byte_t req_wdata,
   input  logic  done
);

   // Two-flop synchronizers plus one delayed copy for edge detect
   logic rd_s1;
   logic rd_s2;
   logic rd_prev;
   logic wr_s1;
   logic wr_s2;
   logic wr_prev;

   logic rd_fall;
   logic wr_fall;

   //////////////////////////////
   // Strobe synchronizers
   //////////////////////////////

   // Strobes idle high, so reset to the inactive level
   always_ff @(posedge CLK) begin
      if (reset) begin
         rd_s1   <= 1'b1;
         rd_s2   <= 1'b1;
         rd_prev <= 1'b1;
         wr_s1   <= 1'b1;
         wr_s2   <= 1'b1;
         wr_prev <= 1'b1;
      end else begin
         rd_s1   <= console_rd_n;
         rd_s2   <= rd_s1;
         rd_prev <= rd_s2;
         wr_s1   <= console_wr_n;
         wr_s2   <= wr_s1;
         wr_prev <= wr_s2;
      end
   end

   // Falling edge of each synchronized strobe
   assign rd_fall = rd_prev & ~rd_s2;
   assign wr_fall = wr_prev & ~wr_s2;

   // Pad driver enable while the console reads
   assign console_oe = ~rd_s2;

   //////////////////////////////
   // Memory request
   //////////////////////////////

   // Held from the strobe edge until the arbiter reports done
   always_ff @(posedge CLK) begin
      if (reset) begin
         req    <= 1'b0;
         req_we <= 1'b0;
      end else if (done) begin
         req <= 1'b0;
      end else if ((rd_fall || wr_fall) && !req) begin
         req    <= 1'b1;
         req_we <= wr_fall;
      end
   end

   // Address and data are stable on the bus by the time the edge is seen
   always_ff @(posedge CLK) begin
      if ((rd_fall || wr_fall) && !req) begin
         req_addr  <= console_addr;
         req_wdata <= console_wdata;
      end
   end

endmodule

// ==== hdl/mcu_port.sv ====
module mcu_port
   import cart_pkg::*;
(
   input  logic  CLK,
   input  logic  reset,
   input  logic  mcu_cyc,
   input  logic  mcu_stb,
   input  logic  mcu_we,
   input  addr_t mcu_adr,
   input  byte_t mcu_dat_w,
   output logic  mcu_ack,
   output logic  req,
   output logic  req_we,
   output addr_t req_addr,
   output byte_t req_wdata,
   input  logic  done
);

   // Set once the current bus cycle has been passed on
   logic busy;
   logic start;

   // New Wishbone cycle not yet requested
   assign start = mcu_cyc & mcu_stb & ~busy & ~mcu_ack;

   //////////////////////////////
   // Request and ack handshake
   //////////////////////////////

   always_ff @(posedge CLK) begin
      if (reset) begin
         req     <= 1'b0;
         req_we  <= 1'b0;
         busy    <= 1'b0;
         mcu_ack <= 1'b0;
      end else begin
         // Ack lasts one cycle only
         mcu_ack <= 1'b0;

         if (mcu_ack) begin
            // Master changes its signals after this edge
            busy <= 1'b0;
         end else if (done) begin
            req <= 1'b0;
            // No ack if the master gave up the cycle meanwhile
            mcu_ack <= mcu_cyc & mcu_stb;
            busy    <= mcu_cyc & mcu_stb;
         end else if (start) begin
            req    <= 1'b1;
            req_we <= mcu_we;
            busy   <= 1'b1;
         end
      end
   end

   // Fields frozen for the whole request
   always_ff @(posedge CLK) begin
      if (start) begin
         req_addr  <= mcu_adr;
         req_wdata <= mcu_dat_w;
      end
   end

endmodule

// ==== hdl/mem_arbiter.sv ====
`include "cart_settings.svh"

module mem_arbiter
   import cart_pkg::*;
(
   input  logic     CLK,
   input  logic     reset,
   input  logic     con_req,
   input  logic     con_we,
   input  addr_t    con_addr,
   input  byte_t    con_wdata,
   output logic     con_done,
   input  logic     mcu_req,
   input  logic     mcu_we,
   input  addr_t    mcu_addr,
   input  byte_t    mcu_wdata,
   output logic     mcu_done,
   output waddr_t   mem_addr,
   output word_t    mem_wdata,
   output lane_en_t mem_be,
   output logic     mem_we,
   output logic     lane_lo,
   output logic     load_console,
   output logic     load_mcu,
   output byte_t    wr_byte
);

   arb_state_t state;

   // Access counter, wide enough for up to 8 cycles
   logic [3:0] cnt;

   // Owner of the current access, 1 for the console
   logic  own_con;
   logic  lat_we;
   addr_t lat_addr;
   byte_t lat_wdata;

   logic grant;
   logic pick_con;

   // Console has fixed priority since its bus cannot wait
   assign pick_con = con_req;
   assign grant    = (state == ARB_IDLE) && (con_req || mcu_req);

   //////////////////////////////
   // Arbiter FSM
   //////////////////////////////

   always_ff @(posedge CLK) begin
      if (reset) begin
         state   <= ARB_IDLE;
         cnt     <= '0;
         own_con <= 1'b0;
         lat_we  <= 1'b0;
      end else begin
         case (state)
            ARB_IDLE: begin
               if (grant) begin
                  state   <= ARB_ACCESS;
                  cnt     <= '0;
                  own_con <= pick_con;
                  lat_we  <= pick_con ? con_we : mcu_we;
               end
            end
            ARB_ACCESS: begin
               if (cnt == 4'(`MEM_CYCLES - 1)) begin
                  state <= ARB_DONE;
               end else begin
                  cnt <= cnt + 4'd1;
               end
            end
            default: begin
               state <= ARB_IDLE;
            end
         endcase
      end
   end

   // Granted address and data
   always_ff @(posedge CLK) begin
      if (grant) begin
         lat_addr  <= pick_con ? con_addr : mcu_addr;
         lat_wdata <= pick_con ? con_wdata : mcu_wdata;
      end
   end

   //////////////////////////////
   // SRAM and steering outputs
   //////////////////////////////

   assign mem_addr  = lat_addr[`CART_ADDR_W-1:1];
   assign mem_wdata = {lat_wdata, lat_wdata};
   assign wr_byte   = lat_wdata;
   assign lane_lo   = lat_addr[0];

   // Enables held through done so the read word is still there at capture
   assign mem_be = (state == ARB_IDLE) ? 2'b00 : (lat_addr[0] ? 2'b01 : 2'b10);
   assign mem_we = (state == ARB_ACCESS) && lat_we;

   assign con_done = (state == ARB_DONE) && own_con;
   assign mcu_done = (state == ARB_DONE) && !own_con;

   // Reads only
   assign load_console = con_done && !lat_we;
   assign load_mcu     = mcu_done && !lat_we;

endmodule

// ==== tb/sram_model.sv ====
module sram_model
   import cart_pkg::*;
(
   input  logic     CLK,
   input  waddr_t   addr,
   input  word_t    wdata,
   input  lane_en_t be,
   input  logic     we,
   output word_t    rdata
);

   timeunit 1ns;
   timeprecision 100ps;

   // 4096 words, upper address bits ignored
   localparam int DEPTH = 4096;

   word_t       mem [DEPTH];
   logic [11:0] idx;

   // Start value of the byte at byte address b
   function automatic byte_t fill_byte(logic [12:0] b);
      return 8'(b * 13'd37) ^ 8'(b >> 5) ^ 8'h3c;
   endfunction

   // Even byte address sits in the high half of the word
   initial begin
      for (int w = 0; w < DEPTH; w++) begin
         mem[w] = {fill_byte({12'(w), 1'b0}), fill_byte({12'(w), 1'b1})};
      end
   end

   assign idx   = addr[11:0];
   assign rdata = mem[idx];

   always @(posedge CLK) begin
      if (we) begin
         if (be[1]) begin
            mem[idx][15:8] <= wdata[15:8];
         end
         if (be[0]) begin
            mem[idx][7:0] <= wdata[7:0];
         end
      end
   end

endmodule

// ==== tb/tb_cart.sv ====
`include "cart_settings.svh"

module tb_cart
   import cart_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_OPS   = 46;
   localparam int ACK_LIMIT = 40;
   localparam int MEM_BYTES = 8192;
   // Console read latency bound from strobe fall to valid data
   localparam int CON_BOUND = 3 + 2 * (`MEM_CYCLES + 1) + 1;
   localparam int CON_HOLD  = CON_BOUND + 2;

   logic     CLK;
   logic     reset;
   addr_t    console_addr;
   logic     console_rd_n;
   logic     console_wr_n;
   byte_t    console_wdata;
   byte_t    console_rdata;
   logic     console_oe;
   logic     mcu_cyc;
   logic     mcu_stb;
   logic     mcu_we;
   addr_t    mcu_adr;
   byte_t    mcu_dat_w;
   byte_t    mcu_dat_r;
   logic     mcu_ack;
   waddr_t   mem_addr;
   word_t    mem_wdata;
   lane_en_t mem_be;
   logic     mem_we;
   word_t    mem_rdata;

   // Expected memory contents with one entry per byte address
   byte_t    shadow [MEM_BYTES];
   lane_en_t last_be;
   int       errors;

   cart_data_top i_dut (.*);

   sram_model i_sram (
      .CLK   (CLK),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .be    (mem_be),
      .we    (mem_we),
      .rdata (mem_rdata)
   );

   initial begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK;
   end

   // Lane enables of the latest SRAM write
   always @(posedge CLK) begin
      if (reset) begin
         last_be <= '0;
      end else if (mem_we) begin
         last_be <= mem_be;
      end
   end

   initial begin
      repeat (NUM_OPS * ACK_LIMIT + 16) @(posedge CLK);
      $display("Watchdog expired after %0d clock periods", NUM_OPS * ACK_LIMIT + 16);
      $display("SOME TESTS FAILED");
      $finish;
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // Power-up byte at byte address b in big-endian words
   function automatic byte_t init_pattern(logic [12:0] b);
      return 8'(b * 13'd37) ^ 8'(b >> 5) ^ 8'h3c;
   endfunction

   task automatic check_value(string name, logic [15:0] exp, logic [15:0] got);
      assert (got === exp) else begin
         $display("FAIL %s expected %h got %h at %0t", name, exp, got, $time);
         errors++;
      end
   endtask

   // Waits on falling edges until ack shows up or the limit runs out
   task automatic wait_ack(output logic seen);
      int n;
      n = 0;
      @(negedge CLK);
      while (!mcu_ack && n < ACK_LIMIT) begin
         @(negedge CLK);
         n++;
      end
      seen = mcu_ack;
   endtask

   task automatic wb_write(addr_t a, byte_t d);
      logic seen;
      mcu_cyc   = 1'b1;
      mcu_stb   = 1'b1;
      mcu_we    = 1'b1;
      mcu_adr   = a;
      mcu_dat_w = d;
      wait_ack(seen);
      assert (seen) else begin
         $display("MCU ack missing for write to address %h", a);
         errors++;
      end
      shadow[int'(a[12:0])] = d;
      mcu_cyc = 1'b0;
      mcu_stb = 1'b0;
      mcu_we  = 1'b0;
      @(negedge CLK);
   endtask

   task automatic wb_read(addr_t a);
      logic  seen;
      byte_t exp;
      exp     = shadow[int'(a[12:0])];
      mcu_cyc = 1'b1;
      mcu_stb = 1'b1;
      mcu_we  = 1'b0;
      mcu_adr = a;
      wait_ack(seen);
      assert (seen) else begin
         $display("MCU ack missing for read from address %h", a);
         errors++;
      end
      if (seen) begin
         check_value("mcu_dat_r", 16'(exp), 16'(mcu_dat_r));
      end
      mcu_cyc = 1'b0;
      mcu_stb = 1'b0;
      @(negedge CLK);
   endtask

   // Strobe falls in cycle 1 and data is sampled at cycle 11
   task automatic console_read(addr_t a);
      byte_t exp;
      exp          = shadow[int'(a[12:0])];
      console_addr = a;
      console_rd_n = 1'b0;
      repeat (CON_BOUND) @(negedge CLK);
      check_value("console_rdata", 16'(exp), 16'(console_rdata));
      check_value("console_oe", 16'(1'b1), 16'(console_oe));
      repeat (CON_HOLD - CON_BOUND) @(negedge CLK);
      console_rd_n = 1'b1;
      repeat (2) @(negedge CLK);
   endtask

   task automatic console_write(addr_t a, byte_t d);
      console_addr  = a;
      console_wdata = d;
      console_wr_n  = 1'b0;
      repeat (CON_HOLD) @(negedge CLK);
      console_wr_n = 1'b1;
      shadow[int'(a[12:0])] = d;
      repeat (2) @(negedge CLK);
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////

   task automatic after_reset_outputs();
      check_value("mcu_ack", 16'(1'b0), 16'(mcu_ack));
      check_value("mem_we", 16'(1'b0), 16'(mem_we));
      check_value("console_oe", 16'(1'b0), 16'(console_oe));
      check_value("mem_be", 16'(2'b00), 16'(mem_be));
   endtask

   // Even address lands on the high lane and odd on the low lane
   task automatic mcu_write_then_read();
      wb_write(24'h000040, 8'ha5);
      check_value("mem_be", 16'(2'b10), 16'(last_be));
      wb_write(24'h000041, 8'h3c);
      check_value("mem_be", 16'(2'b01), 16'(last_be));
      wb_read(24'h000040);
      wb_read(24'h000041);
   endtask

   task automatic console_reads_mcu();
      console_read(24'h000040);
      console_read(24'h000041);
   endtask

   // Each write is followed by a read of its neighbour in the same word
   task automatic mcu_reads_console();
      console_write(24'h000122, 8'h5e);
      wb_read(24'h000122);
      wb_read(24'h000123);
      console_write(24'h000125, 8'hc7);
      wb_read(24'h000125);
      wb_read(24'h000124);
   endtask

   task automatic read_contention();
      fork
         console_read(24'h000122);
         wb_read(24'h000041);
      join
   endtask

   // Eight-byte window so that both lanes of a word get hit often
   task automatic random_mix();
      int unsigned op;
      addr_t       a;
      byte_t       d;
      for (int i = 0; i < 32; i++) begin
         op = $urandom_range(3, 0);
         a  = 24'h000300 + addr_t'($urandom_range(7, 0));
         d  = 8'($urandom);
         case (op)
            0: wb_write(a, d);
            1: wb_read(a);
            2: console_write(a, d);
            default: console_read(a);
         endcase
      end
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      void'($urandom(32'h835b1d97));
      errors        = 0;
      reset         = 1'b1;
      console_addr  = '0;
      console_rd_n  = 1'b1;
      console_wr_n  = 1'b1;
      console_wdata = '0;
      mcu_cyc       = 1'b0;
      mcu_stb       = 1'b0;
      mcu_we        = 1'b0;
      mcu_adr       = '0;
      mcu_dat_w     = '0;
      for (int b = 0; b < MEM_BYTES; b++) begin
         shadow[b] = init_pattern(13'(b));
      end

      repeat (16) @(negedge CLK);
      reset = 1'b0;
      @(negedge CLK);

      after_reset_outputs();
      mcu_write_then_read();
      console_reads_mcu();
      mcu_reads_console();
      read_contention();
      random_mix();

      $display("Summary: %0d errors", errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
